/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu_top
RTL_TOP   ?= cpu_top
SRCS      ?= -f sources.f
OBJ       ?= obj_dir
FLAGS     ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) $(SRCS)

run: build
	@out=$$(./$(OBJ)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(SRCS:tb_cpu_top.sv=) \
		-f sources.f --timescale 1ns/1ps

clean:
	rm -rf $(OBJ)

/* cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define CPU_XLEN      32
`define CPU_REG_AW    5
`define CPU_SHAMT_W   5
`define CPU_WEN_W     4
`define CPU_RESET_PC  32'hBFC0_0000

// instruction field positions
`define CPU_OP_HI     31
`define CPU_OP_LO     26
`define CPU_RS_HI     25
`define CPU_RS_LO     21
`define CPU_RT_HI     20
`define CPU_RT_LO     16
`define CPU_RD_HI     15
`define CPU_RD_LO     11
`define CPU_SA_HI     10
`define CPU_SA_LO     6
`define CPU_FN_HI     5
`define CPU_FN_LO     0
`define CPU_IMM_HI    15
`define CPU_IMM_LO    0

`endif

/* cpu_pkg.sv */
`include "cpu_defs.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0]   word_t;
    typedef logic [`CPU_REG_AW-1:0] reg_addr_t;

    // bit positions inside the one-hot alu_op vector
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_AND  = 2;
    localparam int ALU_OR   = 3;
    localparam int ALU_XOR  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_SLT  = 6;
    localparam int ALU_SLTU = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    // pass src2 through, used by lui
    localparam int ALU_PASS = 10;
    localparam int ALU_N    = 11;

    typedef logic [ALU_N-1:0] alu_op_t;

    typedef enum logic {
        F_IDLE,
        F_WAIT
    } fetch_state_t;

endpackage

/* cpu_top.sv */
`include "cpu_defs.svh"

module cpu_top import cpu_pkg::*; (
    input  logic                  aclk,
    input  logic                  arst_n,
    // instruction memory
    output logic                  inst_req,
    output word_t                 inst_addr,
    input  logic                  inst_rvalid,
    input  word_t                 inst_rdata,
    // trace
    output word_t                 debug_wb_pc,
    output logic [`CPU_WEN_W-1:0] debug_wb_rf_wen,
    output reg_addr_t             debug_wb_rf_wnum,
    output word_t                 debug_wb_rf_wdata
);

    logic  fd_valid;
    word_t fd_pc;
    word_t fd_inst;

    dec_exe_if dx_bus ();
    exe_wb_if  xw_bus ();
    rf_wr_if   rf_bus ();

    fetch_stage u_fetch (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .inst_req    (inst_req),
        .inst_addr   (inst_addr),
        .inst_rvalid (inst_rvalid),
        .inst_rdata  (inst_rdata),
        .fd_valid    (fd_valid),
        .fd_pc       (fd_pc),
        .fd_inst     (fd_inst)
    );

    decode_stage u_decode (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .fd_valid (fd_valid),
        .fd_pc    (fd_pc),
        .fd_inst  (fd_inst),
        .dx       (dx_bus),
        .ex       (xw_bus),
        .rf       (rf_bus)
    );

    exe_stage u_exe (
        .aclk   (aclk),
        .arst_n (arst_n),
        .dx     (dx_bus),
        .xw     (xw_bus)
    );

    wb_stage u_wb (
        .aclk              (aclk),
        .arst_n            (arst_n),
        .xw                (xw_bus),
        .rf                (rf_bus),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

/* decode_stage.sv */
`include "cpu_defs.svh"

module decode_stage import cpu_pkg::*; (
    input  logic      aclk,
    input  logic      arst_n,
    input  logic      fd_valid,
    input  word_t     fd_pc,
    input  word_t     fd_inst,
    dec_exe_if.master dx,
    exe_wb_if.monitor ex,
    rf_wr_if.slave    rf
);

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0C;
    localparam logic [5:0] OP_ORI     = 6'h0D;
    localparam logic [5:0] OP_XORI    = 6'h0E;
    localparam logic [5:0] OP_LUI     = 6'h0F;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2A;
    localparam logic [5:0] FN_SLTU = 6'h2B;

    // register 0 is not stored
    word_t rf_mem [1:31];

    logic [5:0]             opcode;
    logic [5:0]             funct;
    logic [`CPU_SHAMT_W-1:0] sa;
    logic [15:0]            imm;
    reg_addr_t              rs;
    reg_addr_t              rt;
    reg_addr_t              rd;
    reg_addr_t              rd_addr [2];
    word_t                  rd_data [2];
    alu_op_t                alu_op;
    word_t                  src1;
    word_t                  src2;
    reg_addr_t              dest;
    logic                   wen;

    assign opcode = fd_inst[`CPU_OP_HI:`CPU_OP_LO];
    assign funct  = fd_inst[`CPU_FN_HI:`CPU_FN_LO];
    assign rs     = fd_inst[`CPU_RS_HI:`CPU_RS_LO];
    assign rt     = fd_inst[`CPU_RT_HI:`CPU_RT_LO];
    assign rd     = fd_inst[`CPU_RD_HI:`CPU_RD_LO];
    assign sa     = fd_inst[`CPU_SA_HI:`CPU_SA_LO];
    assign imm    = fd_inst[`CPU_IMM_HI:`CPU_IMM_LO];

    assign rd_addr[0] = rs;
    assign rd_addr[1] = rt;

    // youngest producer wins: execute, then writeback, then the file
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (rd_addr[p] == '0) begin
                rd_data[p] = '0;
            end else if (ex.valid && ex.wen && ex.dest == rd_addr[p]) begin
                rd_data[p] = ex.result;
            end else if (rf.valid && rf.wen && rf.dest == rd_addr[p]) begin
                rd_data[p] = rf.result;
            end else begin
                rd_data[p] = rf_mem[rd_addr[p]];
            end
        end
    end

    always_comb begin
        alu_op = '0;
        src1   = rd_data[0];
        src2   = rd_data[1];
        dest   = rd;
        wen    = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                wen = 1'b1;
                case (funct)
                    FN_ADDU: alu_op[ALU_ADD]  = 1'b1;
                    FN_SUBU: alu_op[ALU_SUB]  = 1'b1;
                    FN_AND:  alu_op[ALU_AND]  = 1'b1;
                    FN_OR:   alu_op[ALU_OR]   = 1'b1;
                    FN_XOR:  alu_op[ALU_XOR]  = 1'b1;
                    FN_NOR:  alu_op[ALU_NOR]  = 1'b1;
                    FN_SLT:  alu_op[ALU_SLT]  = 1'b1;
                    FN_SLTU: alu_op[ALU_SLTU] = 1'b1;
                    FN_SLL: begin
                        alu_op[ALU_SLL] = 1'b1;
                        src1            = word_t'(sa);
                    end
                    FN_SRL: begin
                        alu_op[ALU_SRL] = 1'b1;
                        src1            = word_t'(sa);
                    end
                    default: wen = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                alu_op[ALU_ADD] = 1'b1;
                src2            = {{16{imm[15]}}, imm};
                dest            = rt;
                wen             = 1'b1;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                alu_op[ALU_AND] = (opcode == OP_ANDI);
                alu_op[ALU_OR]  = (opcode == OP_ORI);
                alu_op[ALU_XOR] = (opcode == OP_XORI);
                src2            = {16'b0, imm};
                dest            = rt;
                wen             = 1'b1;
            end
            OP_LUI: begin
                alu_op[ALU_PASS] = 1'b1;
                src2             = {imm, 16'b0};
                dest             = rt;
                wen              = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rf.valid && rf.wen && rf.dest != '0) begin
            rf_mem[rf.dest] <= rf.result;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            dx.valid <= 1'b0;
        end else begin
            dx.valid <= fd_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (fd_valid) begin
            dx.pc     <= fd_pc;
            dx.alu_op <= alu_op;
            dx.src1   <= src1;
            dx.src2   <= src2;
            dx.dest   <= dest;
            dx.wen    <= wen;
        end
    end

endmodule

/* exe_stage.sv */
`include "cpu_defs.svh"

module exe_stage import cpu_pkg::*; (
    input  logic      aclk,
    input  logic      arst_n,
    dec_exe_if.slave  dx,
    exe_wb_if.master  xw
);

    word_t                   alu_res;
    logic [`CPU_SHAMT_W-1:0] shamt;
    logic                    lt_s;
    logic                    lt_u;

    assign shamt = dx.src1[`CPU_SHAMT_W-1:0];
    assign lt_s  = $signed(dx.src1) < $signed(dx.src2);
    assign lt_u  = dx.src1 < dx.src2;

    // and-or select over the one-hot op, unknown ops give zero
    always_comb begin
        alu_res = '0;
        if (dx.alu_op[ALU_ADD])  alu_res |= dx.src1 + dx.src2;
        if (dx.alu_op[ALU_SUB])  alu_res |= dx.src1 - dx.src2;
        if (dx.alu_op[ALU_AND])  alu_res |= dx.src1 & dx.src2;
        if (dx.alu_op[ALU_OR])   alu_res |= dx.src1 | dx.src2;
        if (dx.alu_op[ALU_XOR])  alu_res |= dx.src1 ^ dx.src2;
        if (dx.alu_op[ALU_NOR])  alu_res |= ~(dx.src1 | dx.src2);
        if (dx.alu_op[ALU_SLT])  alu_res |= word_t'(lt_s);
        if (dx.alu_op[ALU_SLTU]) alu_res |= word_t'(lt_u);
        if (dx.alu_op[ALU_SLL])  alu_res |= dx.src2 << shamt;
        if (dx.alu_op[ALU_SRL])  alu_res |= dx.src2 >> shamt;
        if (dx.alu_op[ALU_PASS]) alu_res |= dx.src2;
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            xw.valid <= 1'b0;
        end else begin
            xw.valid <= dx.valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (dx.valid) begin
            xw.pc     <= dx.pc;
            xw.dest   <= dx.dest;
            xw.wen    <= dx.wen;
            xw.result <= alu_res;
        end
    end

endmodule

/* fetch_stage.sv */
`include "cpu_defs.svh"

module fetch_stage import cpu_pkg::*; (
    input  logic  aclk,
    input  logic  arst_n,
    // instruction memory port
    output logic  inst_req,
    output word_t inst_addr,
    input  logic  inst_rvalid,
    input  word_t inst_rdata,
    // to decode
    output logic  fd_valid,
    output word_t fd_pc,
    output word_t fd_inst
);

    fetch_state_t state;
    word_t        pc;
    logic         running;
    logic         resp_take;

    // keeps the request low until the first clock after reset
    assign inst_req  = running && (state == F_IDLE);
    assign inst_addr = pc;

    assign resp_take = (state == F_WAIT) && inst_rvalid;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
            state   <= F_IDLE;
            pc      <= `CPU_RESET_PC;
        end else begin
            running <= 1'b1;
            case (state)
                F_IDLE: begin
                    if (running) begin
                        state <= F_WAIT;
                    end
                end
                F_WAIT: begin
                    // one request outstanding, wait for its data
                    if (inst_rvalid) begin
                        state <= F_IDLE;
                        pc    <= pc + word_t'(4);
                    end
                end
                default: begin
                    state <= F_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            fd_valid <= 1'b0;
        end else begin
            fd_valid <= resp_take;
        end
    end

    // fetched instruction and the pc it came from
    always_ff @(posedge aclk) begin
        if (resp_take) begin
            fd_pc   <= pc;
            fd_inst <= inst_rdata;
        end
    end

endmodule

/* pipe_if.sv */
// decode to execute
interface dec_exe_if import cpu_pkg::*; ();
    logic      valid;
    word_t     pc;
    alu_op_t   alu_op;
    word_t     src1;
    word_t     src2;
    reg_addr_t dest;
    logic      wen;

    modport master (output valid, pc, alu_op, src1, src2, dest, wen);
    modport slave  (input  valid, pc, alu_op, src1, src2, dest, wen);
endinterface

// execute to writeback, also watched by decode for forwarding
interface exe_wb_if import cpu_pkg::*; ();
    logic      valid;
    word_t     pc;
    reg_addr_t dest;
    logic      wen;
    word_t     result;

    modport master  (output valid, pc, dest, wen, result);
    modport slave   (input  valid, pc, dest, wen, result);
    modport monitor (input  valid, dest, wen, result);
endinterface

// register file write port from writeback
interface rf_wr_if import cpu_pkg::*; ();
    logic      valid;
    reg_addr_t dest;
    logic      wen;
    word_t     result;

    modport master (output valid, dest, wen, result);
    modport slave  (input  valid, dest, wen, result);
endinterface

/* sources.f */
+incdir+.
cpu_pkg.sv
pipe_if.sv
fetch_stage.sv
decode_stage.sv
exe_stage.sv
wb_stage.sv
cpu_top.sv
tb_cpu_top.sv

/* tb_cpu_top.sv */
`include "cpu_defs.svh"

module tb_cpu_top import cpu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int     PROG_N     = 256;
    localparam int     RST_CYCLES = 10;
    localparam int     WD_CYCLES  = PROG_N * 8 + 100;
    localparam word_t  LFSR_SEED  = 32'd77201;
    localparam word_t  LFSR_TAPS  = 32'h8020_0003;
    // funct codes for kinds 0..9, opcodes for kinds 10..14
    localparam logic [5:0] FN_TAB [10] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26,
                                           6'h27, 6'h2A, 6'h2B, 6'h00, 6'h02};
    localparam logic [5:0] OP_TAB [5]  = '{6'h09, 6'h0C, 6'h0D, 6'h0E, 6'h0F};

    logic                  aclk = 1'b0;
    logic                  arst_n;
    logic                  inst_req;
    word_t                 inst_addr;
    logic                  inst_rvalid;
    word_t                 inst_rdata;
    word_t                 debug_wb_pc;
    logic [`CPU_WEN_W-1:0] debug_wb_rf_wen;
    reg_addr_t             debug_wb_rf_wnum;
    word_t                 debug_wb_rf_wdata;

    word_t     prog [PROG_N];
    word_t     model_rf [32];
    word_t     lfsr;
    word_t     exp_pc [$];
    reg_addr_t exp_num [$];
    word_t     exp_data [$];
    int        errors = 0;
    int        checks = 0;

    cpu_top dut (
        .aclk              (aclk),
        .arst_n            (arst_n),
        .inst_req          (inst_req),
        .inst_addr         (inst_addr),
        .inst_rvalid       (inst_rvalid),
        .inst_rdata        (inst_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #5 aclk = ~aclk;

    function automatic word_t lfsr_next(word_t s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic int unsigned rand_bits(int n);
        int unsigned v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            v = (v << 1) | {31'b0, lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic word_t enc_r(logic [5:0] fn, reg_addr_t rs, reg_addr_t rt,
                                    reg_addr_t rd, logic [4:0] sa);
        word_t w;
        w = '0;
        w[`CPU_RS_HI:`CPU_RS_LO] = rs;
        w[`CPU_RT_HI:`CPU_RT_LO] = rt;
        w[`CPU_RD_HI:`CPU_RD_LO] = rd;
        w[`CPU_SA_HI:`CPU_SA_LO] = sa;
        w[`CPU_FN_HI:`CPU_FN_LO] = fn;
        return w;
    endfunction

    function automatic word_t enc_i(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                    logic [15:0] imm);
        word_t w;
        w = '0;
        w[`CPU_OP_HI:`CPU_OP_LO]   = op;
        w[`CPU_RS_HI:`CPU_RS_LO]   = rs;
        w[`CPU_RT_HI:`CPU_RT_LO]   = rt;
        w[`CPU_IMM_HI:`CPU_IMM_LO] = imm;
        return w;
    endfunction

    // registers 0..7 only, so dependencies are frequent
    function automatic word_t make_inst(int kind);
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [4:0]  sa;
        logic [15:0] imm;
        rs  = reg_addr_t'(rand_bits(3));
        rt  = reg_addr_t'(rand_bits(3));
        rd  = reg_addr_t'(rand_bits(3));
        sa  = 5'(rand_bits(5));
        imm = 16'(rand_bits(16));
        if (kind < 8) return enc_r(FN_TAB[kind], rs, rt, rd, 5'd0);
        if (kind < 10) return enc_r(FN_TAB[kind], 5'd0, rt, rd, sa);
        if (kind < 15) return enc_i(OP_TAB[kind-10], rs, rt, imm);
        // sw or mult, neither is implemented
        return (rand_bits(1) != 0) ? enc_i(6'h2B, rs, rt, imm) : enc_r(6'h18, rs, rt, rd, sa);
    endfunction

    // in-order instruction set model, returns 1 for a traced write
    function automatic bit ref_exec(input word_t inst, output reg_addr_t dst, output word_t val);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  sa;
        logic [15:0] imm;
        word_t       a;
        word_t       b;
        bit          wr;
        op  = inst[`CPU_OP_HI:`CPU_OP_LO];
        fn  = inst[`CPU_FN_HI:`CPU_FN_LO];
        sa  = inst[`CPU_SA_HI:`CPU_SA_LO];
        imm = inst[`CPU_IMM_HI:`CPU_IMM_LO];
        a   = model_rf[inst[`CPU_RS_HI:`CPU_RS_LO]];
        b   = model_rf[inst[`CPU_RT_HI:`CPU_RT_LO]];
        dst = inst[`CPU_RT_HI:`CPU_RT_LO];
        val = '0;
        wr  = 1'b1;
        case (op)
            6'h00: begin
                dst = inst[`CPU_RD_HI:`CPU_RD_LO];
                case (fn)
                    6'h21: val = a + b;
                    6'h23: val = a - b;
                    6'h24: val = a & b;
                    6'h25: val = a | b;
                    6'h26: val = a ^ b;
                    6'h27: val = ~(a | b);
                    6'h2A: val = {31'b0, $signed(a) < $signed(b)};
                    6'h2B: val = {31'b0, a < b};
                    6'h00: val = b << sa;
                    6'h02: val = b >> sa;
                    default: wr = 1'b0;
                endcase
            end
            6'h09: val = a + {{16{imm[15]}}, imm};
            6'h0C: val = a & {16'b0, imm};
            6'h0D: val = a | {16'b0, imm};
            6'h0E: val = a ^ {16'b0, imm};
            6'h0F: val = {imm, 16'b0};
            default: wr = 1'b0;
        endcase
        if (wr && dst != '0) model_rf[dst] = val;
        return wr && (dst != '0);
    endfunction

    task automatic check(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    // instruction memory, latency 1 for the first half, then 1 to 4
    initial begin
        int    req_idx;
        int    lat;
        word_t exp_addr;
        word_t off;
        req_idx  = 0;
        exp_addr = `CPU_RESET_PC;
        @(posedge arst_n);
        forever begin
            if (inst_req) begin
                check("inst_addr", inst_addr, exp_addr);
                off      = (inst_addr - `CPU_RESET_PC) >> 2;
                exp_addr = exp_addr + 32'd4;
                lat      = (req_idx < PROG_N / 2) ? 1 : 1 + int'(rand_bits(2));
                req_idx++;
                repeat (lat) @(posedge aclk);
                #1;
                inst_rvalid = 1'b1;
                // past the program, unimplemented opcodes keyed to the address
                inst_rdata  = (off < PROG_N) ? prog[off] :
                              {6'h3F, inst_addr[31:6] ^ inst_addr[25:0]};
                @(posedge aclk);
                #1;
                inst_rvalid = 1'b0;
            end else begin
                @(posedge aclk);
                #1;
            end
        end
    end

    always @(negedge aclk) begin
        if (arst_n && debug_wb_rf_wen != '0) begin
            if (exp_pc.size() == 0) begin
                errors++;
                $display("trace write at %0t after all expected writes were seen", $time);
            end else begin
                check("debug_wb_rf_wen", word_t'(debug_wb_rf_wen), word_t'({`CPU_WEN_W{1'b1}}));
                check("debug_wb_pc", debug_wb_pc, exp_pc.pop_front());
                check("debug_wb_rf_wnum", word_t'(debug_wb_rf_wnum), word_t'(exp_num.pop_front()));
                check("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_data.pop_front());
            end
        end
    end

    initial begin
        repeat (RST_CYCLES + WD_CYCLES) @(posedge aclk);
        $display("pipeline stalled, %0d trace writes still missing", exp_pc.size());
        $display("TB FAILED");
        $finish;
    end

    initial begin
        reg_addr_t d;
        word_t     v;
        arst_n      = 1'b0;
        inst_rvalid = 1'b0;
        inst_rdata  = '0;
        lfsr        = LFSR_SEED;
        for (int r = 0; r < 32; r++) model_rf[r] = '0;
        // seed r1..r7, then every kind once, then random kinds
        for (int k = 1; k < 8; k++) prog[k-1] = enc_i(6'h09, 5'd0, 5'(k), 16'(rand_bits(16)));
        for (int i = 7; i < PROG_N; i++) begin
            prog[i] = make_inst((i < 23) ? i - 7 : int'(rand_bits(4)));
        end
        for (int i = 0; i < PROG_N; i++) begin
            if (ref_exec(prog[i], d, v)) begin
                exp_pc.push_back(`CPU_RESET_PC + word_t'(i * 4));
                exp_num.push_back(d);
                exp_data.push_back(v);
            end
        end
        repeat (RST_CYCLES) @(posedge aclk);
        check("inst_req", word_t'(inst_req), 32'd0);
        check("debug_wb_rf_wen", word_t'(debug_wb_rf_wen), 32'd0);
        #1;
        arst_n = 1'b1;
        @(posedge aclk);
        #1;
        check("inst_req", word_t'(inst_req), 32'd1);
        while (exp_pc.size() != 0) @(posedge aclk);
        // catch stray writes after the program
        repeat (20) @(posedge aclk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* wb_stage.sv */
`include "cpu_defs.svh"

module wb_stage import cpu_pkg::*; (
    input  logic                  aclk,
    input  logic                  arst_n,
    exe_wb_if.slave               xw,
    rf_wr_if.master               rf,
    output word_t                 debug_wb_pc,
    output logic [`CPU_WEN_W-1:0] debug_wb_rf_wen,
    output reg_addr_t             debug_wb_rf_wnum,
    output word_t                 debug_wb_rf_wdata
);

    logic      wb_valid;
    word_t     wb_pc;
    reg_addr_t wb_dest;
    logic      wb_wen;
    word_t     wb_result;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= xw.valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (xw.valid) begin
            wb_pc     <= xw.pc;
            wb_dest   <= xw.dest;
            wb_wen    <= xw.wen;
            wb_result <= xw.result;
        end
    end

    assign rf.valid  = wb_valid;
    assign rf.dest   = wb_dest;
    assign rf.wen    = wb_wen;
    assign rf.result = wb_result;

    // writes to $0 stay off the trace
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wen   = {`CPU_WEN_W{wb_valid && wb_wen && (wb_dest != '0)}};
    assign debug_wb_rf_wnum  = wb_dest;
    assign debug_wb_rf_wdata = wb_result;

endmodule
